//--- hw/gpio_chaser_pkg.sv
// GPIO chaser shared widths and logic-analyzer probe line positions

package gpio_chaser_pkg;

    // Prescaler input width in bits
    // One count is one millisecond of dwell
    localparam int PRESCALER_W = 14;

    // Divider count and dwell period width
    localparam int DIV_W = 28;  // Holds 16383 * 10000 with room to spare

    // GPIO port width of the user area
    localparam int GPIO_W = 34;

    // Logic-analyzer probe bus width
    localparam int LA_W = 128;

    // Probe line that carries enable
    localparam int LA_ENABLE_BIT = 0;

    // Probe line that carries stop
    localparam int LA_STOP_BIT = 1;  // Wins over enable

endpackage : gpio_chaser_pkg

//--- hw/tick_divider.sv
// Tick divider that turns run cycles into one-cycle dwell ticks every prescaler ms

`default_nettype none

module tick_divider #(
    parameter int CYCLES_PER_MS = 10000  // Clock cycles in one millisecond
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   run,       // Count enable
    input  logic                                   clear,     // Back to zero and no tick
    input  logic [gpio_chaser_pkg::PRESCALER_W-1:0] prescaler, // Dwell in ms
    output logic                                   tick       // One cycle per dwell
);

    logic [gpio_chaser_pkg::DIV_W-1:0] period;   // Dwell length in cycles
    logic [gpio_chaser_pkg::DIV_W-1:0] count;    // Cycles spent in current dwell
    logic                              period_ok; // Nonzero dwell
    logic                              last_cycle;

    // Dwell period from the prescaler
    // Zero-extend before the multiply so the product is not truncated
    assign period = gpio_chaser_pkg::DIV_W'(prescaler)
                  * gpio_chaser_pkg::DIV_W'(CYCLES_PER_MS);

    assign period_ok = (period != '0);  // Zero period stays silent

    // Greater-or-equal catches a prescaler that shrank mid-dwell
    assign last_cycle = (count >= period - 1'b1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
            tick  <= 1'b0;
        end else if (clear) begin    // Stop wins over run
            count <= '0;
            tick  <= 1'b0;
        end else if (run && period_ok) begin
            if (last_cycle) begin
                count <= '0;         // Restart the dwell
                tick  <= 1'b1;       // Registered pulse at the boundary
            end else begin
                count <= count + 1'b1;
                tick  <= 1'b0;
            end
        end else begin
            tick <= 1'b0;            // Frozen count and no pulse
        end
    end

    // A tick leaves the count at zero
    // so a second tick right away needs a one-cycle period
    tick_spacing_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        (tick && (period > gpio_chaser_pkg::DIV_W'(1))) |=> !tick
    ) else $error("tick_divider: back-to-back ticks with period above one");

    // Stop must silence the tick on the following cycle
    clear_quiet_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        clear |=> !tick
    ) else $error("tick_divider: tick after clear");

endmodule : tick_divider

`default_nettype wire

//--- hw/pin_sequencer.sv
// Pin sequencer that walks a one-hot GPIO pattern on dwell ticks and flags done

`default_nettype none

module pin_sequencer #(
    parameter int NUM_PINS = 34  // Pins in the chase
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                tick,     // Advance by one step
    input  logic                clear,    // Back to idle
    output logic [NUM_PINS-1:0] gpio_out, // One-hot active pin
    output logic                done      // High for the step after the last pin
);

    // Step 0 is idle, 1 to NUM_PINS drive a pin, NUM_PINS + 1 is done
    localparam int STEP_W = $clog2(NUM_PINS + 2);

    localparam logic [STEP_W-1:0] FIRST_STEP = STEP_W'(1);
    localparam logic [STEP_W-1:0] LAST_STEP  = STEP_W'(NUM_PINS + 1);

    logic [STEP_W-1:0] step;       // Registered position in the chase
    logic [STEP_W-1:0] step_next;

    // Next step on a tick
    // Done wraps back to the first pin and skips idle
    always_comb begin
        if (step == LAST_STEP) begin
            step_next = FIRST_STEP;
        end else begin
            step_next = step + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            step <= '0;
        end else if (clear) begin   // Stop takes priority over tick
            step <= '0;
        end else if (tick) begin
            step <= step_next;
        end
    end

    // Index to one-hot decode straight off the register
    always_comb begin
        for (int i = 0; i < NUM_PINS; i++) begin
            gpio_out[i] = (step == STEP_W'(i + 1));  // Pin i lit on step i+1
        end
    end

    assign done = (step == LAST_STEP);  // Whole dwell after the last pin

    // At most one pin lit at any time
    onehot_pins_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(gpio_out)
    ) else $error("pin_sequencer: more than one pin high");

    // Done only while every pin is off
    done_exclusive_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(done && (|gpio_out))
    ) else $error("pin_sequencer: done overlaps an active pin");

    // Step stays within the chase
    step_range_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        step <= LAST_STEP
    ) else $error("pin_sequencer: step out of range");

endmodule : pin_sequencer

`default_nettype wire

//--- hw/gpio_chaser_top.sv
// GPIO chaser top level with probe decode, divider to sequencer chain and tie-offs

`default_nettype none

module gpio_chaser_top #(
    parameter int CYCLES_PER_MS = 10000,                    // 10 MHz clock
    parameter int NUM_PINS      = gpio_chaser_pkg::GPIO_W   // Pins in the chase
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    en,        // Chip enable from the harness
    input  logic [gpio_chaser_pkg::PRESCALER_W-1:0] prescaler, // Dwell per pin in ms
    output logic                                    done,      // Sequence finished

    // Logic-analyzer probes
    input  logic [gpio_chaser_pkg::LA_W-1:0]        la_data_in,
    output logic [gpio_chaser_pkg::LA_W-1:0]        la_data_out,
    input  logic [gpio_chaser_pkg::LA_W-1:0]        la_oenb,   // Active low per line

    // Breakout board pins
    input  logic [gpio_chaser_pkg::GPIO_W-1:0]      gpio_in,   // Not used by the chaser
    output logic [gpio_chaser_pkg::GPIO_W-1:0]      gpio_out,
    output logic [gpio_chaser_pkg::GPIO_W-1:0]      gpio_oeb   // Active low output enable
);

    // Chase must fit on the port
    if (NUM_PINS < 1 || NUM_PINS > gpio_chaser_pkg::GPIO_W) begin : g_pins_check
        $error("gpio_chaser_top: NUM_PINS must be 1 to GPIO_W");
    end

    logic                enable_probe; // Qualified enable line
    logic                stop_probe;   // Qualified stop line
    logic                run;
    logic                clear;
    logic                tick;         // Dwell boundary pulse
    logic [NUM_PINS-1:0] seq_gpio;     // Sequencer pins before widening

    // A probe line only counts while its oenb bit is low
    assign enable_probe = la_data_in[gpio_chaser_pkg::LA_ENABLE_BIT]
                        & ~la_oenb[gpio_chaser_pkg::LA_ENABLE_BIT];
    assign stop_probe   = la_data_in[gpio_chaser_pkg::LA_STOP_BIT]
                        & ~la_oenb[gpio_chaser_pkg::LA_STOP_BIT];

    assign run   = en & enable_probe;  // Both enables must agree
    assign clear = stop_probe;         // Priority handled in each block

    tick_divider #(
        .CYCLES_PER_MS(CYCLES_PER_MS)
    ) tick_divider_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .run      (run),
        .clear    (clear),
        .prescaler(prescaler),
        .tick     (tick)
    );

    pin_sequencer #(
        .NUM_PINS(NUM_PINS)
    ) pin_sequencer_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .tick    (tick),
        .clear   (clear),
        .gpio_out(seq_gpio),
        .done    (done)
    );

    // Pins above NUM_PINS stay low
    always_comb begin
        gpio_out                 = '0;
        gpio_out[NUM_PINS-1:0]   = seq_gpio;
    end

    assign gpio_oeb    = '0;  // Every pin is an output
    assign la_data_out = '0;  // Nothing reported back on the probes

endmodule : gpio_chaser_top

`default_nettype wire

//--- verification/gpio_chaser_tb.sv
// GPIO chaser testbench driving a stimulus table against a cycle model of the chase

module gpio_chaser_tb;

    localparam int CYCLES_PER_MS = 3;   // Short dwell for simulation
    localparam int NUM_PINS      = 34;

    // Row modes
    localparam int MODE_HOLD   = 0;     // Hold for a fixed count
    localparam int MODE_DONE   = 1;     // Wait for done, then hold
    localparam int MODE_RANDOM = 2;     // Hold length from the LFSR
    localparam int MODE_QUIET  = 3;     // Hold and expect no activity

    typedef struct packed {
        logic [gpio_chaser_pkg::PRESCALER_W-1:0] prescaler;
        logic                                    en;
        logic                                    la_en;    // Enable probe level
        logic                                    la_stop;  // Stop probe level
        logic [1:0]                              oenb;     // Bit 0 enable, bit 1 stop
        int                                      hold;     // Cycles after the row starts
        int                                      mode;
    } row_t;

    logic                                    clk;
    logic                                    rst_n;
    logic                                    en;
    logic [gpio_chaser_pkg::PRESCALER_W-1:0] prescaler;
    logic                                    done;
    logic [gpio_chaser_pkg::LA_W-1:0]        la_data_in;
    logic [gpio_chaser_pkg::LA_W-1:0]        la_data_out;
    logic [gpio_chaser_pkg::LA_W-1:0]        la_oenb;
    logic [gpio_chaser_pkg::GPIO_W-1:0]      gpio_in;
    logic [gpio_chaser_pkg::GPIO_W-1:0]      gpio_out;
    logic [gpio_chaser_pkg::GPIO_W-1:0]      gpio_oeb;

    row_t        rows[$];
    logic [31:0] lfsr_state = 32'hb60f4cd6;
    logic        check_en = 1'b0;   // Compare only once reset has taken hold

    // Model state
    int   m_count;                  // Run cycles into the dwell
    logic m_tick;                   // Registered dwell pulse
    int   m_step;                   // 0 idle, 1..NUM_PINS pin, NUM_PINS+1 done

    gpio_chaser_top #(
        .CYCLES_PER_MS(CYCLES_PER_MS),
        .NUM_PINS     (NUM_PINS)
    ) dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (en),
        .prescaler  (prescaler),
        .done       (done),
        .la_data_in (la_data_in),
        .la_data_out(la_data_out),
        .la_oenb    (la_oenb),
        .gpio_in    (gpio_in),
        .gpio_out   (gpio_out),
        .gpio_oeb   (gpio_oeb)
    );

    always #20 clk = ~clk;          // 40 unit period

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("FAIL: see errors above");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // Galois LFSR, polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    function automatic int draw_bits(input int n);
        int v;
        int i;
        v = 0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);   // One step per bit
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    // One-hot pin pattern for a chase step
    function automatic logic [gpio_chaser_pkg::GPIO_W-1:0] expected_gpio(input int step);
        logic [gpio_chaser_pkg::GPIO_W-1:0] v;
        v = '0;
        if (step >= 1 && step <= NUM_PINS) begin
            v = {{(gpio_chaser_pkg::GPIO_W - 1){1'b0}}, 1'b1} << (step - 1);
        end
        return v;
    endfunction

    task automatic add_row(input int psc, input logic e, input logic le, input logic ls,
                           input logic [1:0] oe, input int hold, input int mode);
        row_t r;
        r.prescaler = gpio_chaser_pkg::PRESCALER_W'(psc);
        r.en        = e;
        r.la_en     = le;
        r.la_stop   = ls;
        r.oenb      = oe;
        r.hold      = hold;
        r.mode      = mode;
        rows.push_back(r);
    endtask

    // Cycle model, reads the inputs as they stood before this edge
    always @(posedge clk) begin
        int   period;
        logic run_m;
        logic stop_m;
        period = int'(prescaler) * CYCLES_PER_MS;   // Dwell in cycles
        run_m  = en & la_data_in[gpio_chaser_pkg::LA_ENABLE_BIT]
               & ~la_oenb[gpio_chaser_pkg::LA_ENABLE_BIT];
        stop_m = la_data_in[gpio_chaser_pkg::LA_STOP_BIT]
               & ~la_oenb[gpio_chaser_pkg::LA_STOP_BIT];
        if (!rst_n) begin
            m_count = 0;
            m_tick  = 1'b0;
            m_step  = 0;
        end else if (stop_m) begin          // Stop beats enable
            m_count = 0;
            m_tick  = 1'b0;
            m_step  = 0;
        end else begin
            if (m_tick) begin               // Step follows the pulse by one edge
                m_step = (m_step == NUM_PINS + 1) ? 1 : m_step + 1;
            end
            if (run_m && period > 0) begin
                if (m_count + 1 >= period) begin
                    m_count = 0;
                    m_tick  = 1'b1;
                end else begin
                    m_count = m_count + 1;
                    m_tick  = 1'b0;
                end
            end else begin
                m_tick = 1'b0;              // Frozen, no pulse
            end
        end
    end

    // Outputs compared mid-cycle where they are settled
    always @(negedge clk) begin
        if (check_en) begin
            assert (gpio_out === expected_gpio(m_step)) else
                stop_run($sformatf("Mismatch at time %0t: gpio_out %h, expected %h",
                                   $time, gpio_out, expected_gpio(m_step)));
            assert (done === (m_step == NUM_PINS + 1)) else
                stop_run($sformatf("Mismatch at time %0t: done %b, expected %b",
                                   $time, done, (m_step == NUM_PINS + 1)));
            assert (gpio_oeb === '0) else
                stop_run($sformatf("Mismatch at time %0t: gpio_oeb %h, expected all low",
                                   $time, gpio_oeb));
            assert (la_data_out === '0) else
                stop_run($sformatf("Mismatch at time %0t: la_data_out %h, expected zero",
                                   $time, la_data_out));
        end
    end

    initial begin
        row_t r;
        int   i;
        int   c;
        int   limit;
        logic seen;

        clk        = 1'b0;
        rst_n      = 1'b0;
        en         = 1'b0;
        prescaler  = '0;
        la_data_in = '0;
        la_oenb    = '1;                    // Probes start undriven
        gpio_in    = 34'h2_a5c3_0f96;       // Ignored by the chaser

        add_row(1, 1'b0, 1'b0, 1'b0, 2'b11, 6, MODE_HOLD);     // Idle
        add_row(1, 1'b1, 1'b1, 1'b0, 2'b00, 12, MODE_DONE);    // Full chase and restart
        add_row(1, 1'b1, 1'b1, 1'b0, 2'b00, 0, MODE_RANDOM);   // Run to a random pin
        add_row(1, 1'b1, 1'b1, 1'b1, 2'b00, 9, MODE_HOLD);     // Stop with enable high
        add_row(1, 1'b1, 1'b1, 1'b0, 2'b00, 10, MODE_HOLD);    // Fresh start from idle
        add_row(1, 1'b0, 1'b1, 1'b0, 2'b00, 7, MODE_HOLD);     // en low freezes
        add_row(1, 1'b1, 1'b1, 1'b0, 2'b00, 5, MODE_HOLD);
        add_row(1, 1'b1, 1'b0, 1'b0, 2'b00, 7, MODE_HOLD);     // Probe low freezes
        add_row(1, 1'b1, 1'b1, 1'b0, 2'b00, 4, MODE_HOLD);
        add_row(1, 1'b1, 1'b1, 1'b0, 2'b01, 7, MODE_HOLD);     // Probe not valid
        add_row(1, 1'b1, 1'b1, 1'b1, 2'b10, 8, MODE_HOLD);     // Stop line not valid
        add_row(2, 1'b1, 1'b1, 1'b1, 2'b00, 3, MODE_HOLD);     // Stop, new prescaler
        add_row(2, 1'b1, 1'b1, 1'b0, 2'b00, 15, MODE_DONE);    // Six cycle dwell
        add_row(0, 1'b1, 1'b1, 1'b1, 2'b00, 3, MODE_HOLD);
        add_row(0, 1'b1, 1'b1, 1'b0, 2'b00, 300, MODE_QUIET);  // No ticks at all
        add_row(0, 1'b0, 1'b0, 1'b0, 2'b11, 4, MODE_HOLD);

        // Reset held for two edges
        @(posedge clk);
        check_en = 1'b1;
        @(posedge clk);
        rst_n <= 1'b1;

        for (i = 0; i < rows.size(); i++) begin
            r = rows[i];
            if (r.mode == MODE_RANDOM) begin
                r.hold = 5 + draw_bits(6);  // 5 to 68 cycles
            end
            @(posedge clk);
            prescaler                                <= r.prescaler;
            en                                       <= r.en;
            la_data_in[gpio_chaser_pkg::LA_ENABLE_BIT] <= r.la_en;
            la_data_in[gpio_chaser_pkg::LA_STOP_BIT]   <= r.la_stop;
            la_oenb[gpio_chaser_pkg::LA_ENABLE_BIT]    <= r.oenb[0];
            la_oenb[gpio_chaser_pkg::LA_STOP_BIT]      <= r.oenb[1];

            if (r.mode == MODE_DONE) begin
                // Two whole chases is plenty
                limit = 2 * (NUM_PINS + 2) * int'(r.prescaler) * CYCLES_PER_MS + 20;
                seen  = 1'b0;
                for (c = 0; c < limit && !seen; c++) begin
                    @(negedge clk);
                    if (done === 1'b1) begin
                        seen = 1'b1;
                    end
                end
                if (!seen) begin
                    stop_run($sformatf("Timed out after %0d cycles waiting for done", limit));
                end
            end

            if (r.mode == MODE_QUIET) begin
                for (c = 0; c < r.hold; c++) begin
                    @(negedge clk);
                    assert (gpio_out === '0 && done === 1'b0) else
                        stop_run($sformatf("Mismatch at time %0t: activity with prescaler 0",
                                           $time));
                end
            end else begin
                for (c = 0; c < r.hold; c++) begin
                    @(posedge clk);
                end
            end
        end

        @(negedge clk);
        $display("PASS: all tests");
        $finish;
    end

endmodule : gpio_chaser_tb

//--- sources.f
hw/gpio_chaser_pkg.sv
hw/tick_divider.sv
hw/pin_sequencer.sv
hw/gpio_chaser_top.sv
verification/gpio_chaser_tb.sv

//--- Makefile
# Verilator build and run for the GPIO chaser testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= gpio_chaser_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
FAIL_TEXT ?= FAIL: see errors above
PASS_TEXT ?= PASS: all tests

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

# Build the simulation binary
compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Run and judge the log
run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
